//--- axis_resize_top.f
+incdir+include
hdl/axis_resize_pkg.sv
hdl/axis_skid_slice.sv
hdl/axis_downsizer.sv
hdl/axis_upsizer.sv
hdl/axis_resize_top.sv
sim/axis_resize_checker.sv
sim/tb_axis_resize_top.sv

//--- hdl/axis_downsizer.sv
// axis downsizer
// splits each input word into DOWN subword beats, lowest subword first,
// last only on the final subword of a last word
`timescale 1ns/1ps

module axis_downsizer
  import axis_resize_pkg::*;
#(
  parameter int DWIDTH_IN = 24,
  parameter int DOWN      = 3
) (
  input  logic                                     clk,
  input  logic                                     rst_n_i,
  input  logic                                     s_valid_i,
  output logic                                     s_ready_o,
  input  logic [DWIDTH_IN-1:0]                     s_data_i,
  input  logic                                     s_last_i,
  output logic                                     m_valid_o,
  input  logic                                     m_ready_i,
  output logic [subword_width(DWIDTH_IN, DOWN)-1:0] m_data_o,
  output logic                                     m_last_o
);

  localparam int SW = subword_width(DWIDTH_IN, DOWN);
  localparam int CW = count_width(DOWN);

  logic [DWIDTH_IN-1:0] word_q;
  logic                 last_q;
  logic [CW-1:0]        idx_q;
  logic                 valid_q;
  logic                 final_beat;
  logic                 s_fire;
  logic                 m_fire;

  assign final_beat = (idx_q == CW'(DOWN - 1));
  assign m_fire     = valid_q && m_ready_i;
  assign s_fire     = s_valid_i && s_ready_o;

  // reload in the same cycle the final subword leaves, so no bubble
  assign s_ready_o = !valid_q || (m_ready_i && final_beat);

  // current subword always sits in the low bits of the shift register
  assign m_valid_o = valid_q;
  assign m_data_o  = word_q[SW-1:0];
  assign m_last_o  = last_q && final_beat;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      idx_q   <= '0;
    end else begin
      if (s_fire) begin
        valid_q <= 1'b1;
        idx_q   <= '0;
      end else if (m_fire) begin
        if (final_beat) begin
          valid_q <= 1'b0;
          idx_q   <= '0;
        end else begin
          idx_q <= idx_q + CW'(1);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s_fire) begin
      word_q <= s_data_i;
      last_q <= s_last_i;
    end else if (m_fire && !final_beat) begin
      word_q <= word_q >> SW;
    end
  end

endmodule

//--- hdl/axis_resize_pkg.sv
// axis width converter package
// width derivation helpers shared by all converter stages
`include "axis_resize_defs.svh"

package axis_resize_pkg;

  // limit a derived width to the largest supported port
  function automatic int clamp_width(input int width);
    return (width > `AXIS_RESIZE_MAX_WIDTH) ? `AXIS_RESIZE_MAX_WIDTH : width;
  endfunction

  // width of one subword after splitting the input word
  function automatic int subword_width(input int dwidth_in, input int down);
    return clamp_width(dwidth_in / down);
  endfunction

  // width of a packed output word
  function automatic int out_width(input int dwidth_in, input int down, input int up);
    return clamp_width(subword_width(dwidth_in, down) * up);
  endfunction

  // bits needed to count beats 0 .. ratio-1, at least one bit
  function automatic int count_width(input int ratio);
    return (ratio <= 1) ? 1 : $clog2(ratio);
  endfunction

endpackage

//--- hdl/axis_resize_top.sv
// axis width converter top
// input slice, downsizer, upsizer and output slice in one stream pipeline
`timescale 1ns/1ps
`include "axis_resize_defs.svh"

module axis_resize_top
  import axis_resize_pkg::*;
#(
  parameter int DWIDTH_IN = `AXIS_RESIZE_DEF_DWIDTH_IN,
  parameter int DOWN      = `AXIS_RESIZE_DEF_DOWN,
  parameter int UP        = `AXIS_RESIZE_DEF_UP
) (
  input  logic                                       clk,
  input  logic                                       rst_n_i,
  input  logic                                       s_valid_i,
  output logic                                       s_ready_o,
  input  logic [DWIDTH_IN-1:0]                       s_data_i,
  input  logic                                       s_last_i,
  output logic                                       m_valid_o,
  input  logic                                       m_ready_i,
  output logic [out_width(DWIDTH_IN, DOWN, UP)-1:0]   m_data_o,
  output logic                                       m_last_o
);

  localparam int SW = subword_width(DWIDTH_IN, DOWN);
  localparam int OW = out_width(DWIDTH_IN, DOWN, UP);

  typedef struct packed {
    logic [DWIDTH_IN-1:0] data;
    logic                 last;
  } in_beat_t;

  typedef struct packed {
    logic [OW-1:0] data;
    logic          last;
  } out_beat_t;

  in_beat_t  s_beat;
  in_beat_t  in_beat;
  out_beat_t up_beat;
  out_beat_t m_beat;

  // input slice to downsizer
  logic          in_valid;
  logic          in_ready;
  // downsizer to upsizer, one subword per beat
  logic          sub_valid;
  logic          sub_ready;
  logic [SW-1:0] sub_data;
  logic          sub_last;
  // upsizer to output slice
  logic          up_valid;
  logic          up_ready;

  assign s_beat    = '{data: s_data_i, last: s_last_i};
  assign m_data_o  = m_beat.data;
  assign m_last_o  = m_beat.last;

  axis_skid_slice #(.payload_t(in_beat_t)) u_in_slice (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .s_valid_i  (s_valid_i),
    .s_ready_o  (s_ready_o),
    .s_payload_i(s_beat),
    .m_valid_o  (in_valid),
    .m_ready_i  (in_ready),
    .m_payload_o(in_beat)
  );

  axis_downsizer #(.DWIDTH_IN(DWIDTH_IN), .DOWN(DOWN)) u_down (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .s_valid_i(in_valid),
    .s_ready_o(in_ready),
    .s_data_i (in_beat.data),
    .s_last_i (in_beat.last),
    .m_valid_o(sub_valid),
    .m_ready_i(sub_ready),
    .m_data_o (sub_data),
    .m_last_o (sub_last)
  );

  axis_upsizer #(.DWIDTH_IN(DWIDTH_IN), .DOWN(DOWN), .UP(UP)) u_up (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .s_valid_i(sub_valid),
    .s_ready_o(sub_ready),
    .s_data_i (sub_data),
    .s_last_i (sub_last),
    .m_valid_o(up_valid),
    .m_ready_i(up_ready),
    .m_data_o (up_beat.data),
    .m_last_o (up_beat.last)
  );

  axis_skid_slice #(.payload_t(out_beat_t)) u_out_slice (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .s_valid_i  (up_valid),
    .s_ready_o  (up_ready),
    .s_payload_i(up_beat),
    .m_valid_o  (m_valid_o),
    .m_ready_i  (m_ready_i),
    .m_payload_o(m_beat)
  );

endmodule

//--- hdl/axis_skid_slice.sv
// axis register slice
// two-entry main/skid buffer with registered ready, full throughput,
// generic payload type
`timescale 1ns/1ps

module axis_skid_slice #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     rst_n_i,
  input  logic     s_valid_i,
  output logic     s_ready_o,
  input  payload_t s_payload_i,
  output logic     m_valid_o,
  input  logic     m_ready_i,
  output payload_t m_payload_o
);

  logic     main_valid;
  logic     skid_valid;
  payload_t main_payload;
  payload_t skid_payload;
  logic     main_load;
  logic     s_fire;

  // main register may load when empty or when its beat leaves this cycle
  assign main_load = m_ready_i || !main_valid;
  assign s_fire    = s_valid_i && s_ready_o;

  // ready comes straight from a flop, skid empty means room for one more
  assign s_ready_o   = !skid_valid;
  assign m_valid_o   = main_valid;
  assign m_payload_o = main_payload;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else begin
      if (main_load) begin
        if (skid_valid) begin
          // drain the parked beat first to keep order
          main_valid <= 1'b1;
          skid_valid <= 1'b0;
        end else begin
          main_valid <= s_valid_i;
        end
      end else if (s_fire) begin
        // downstream stalled, park the incoming beat
        skid_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (main_load) begin
      if (skid_valid) begin
        main_payload <= skid_payload;
      end else if (s_valid_i) begin
        main_payload <= s_payload_i;
      end
    end else if (s_fire) begin
      skid_payload <= s_payload_i;
    end
  end

endmodule

//--- hdl/axis_upsizer.sv
// axis upsizer
// packs UP subword beats into one output word, first subword in the low slot;
// a last subword flushes a short word with its empty high slots zeroed
`timescale 1ns/1ps

module axis_upsizer
  import axis_resize_pkg::*;
#(
  parameter int DWIDTH_IN = 24,
  parameter int DOWN      = 3,
  parameter int UP        = 2
) (
  input  logic                                       clk,
  input  logic                                       rst_n_i,
  input  logic                                       s_valid_i,
  output logic                                       s_ready_o,
  input  logic [subword_width(DWIDTH_IN, DOWN)-1:0]   s_data_i,
  input  logic                                       s_last_i,
  output logic                                       m_valid_o,
  input  logic                                       m_ready_i,
  output logic [out_width(DWIDTH_IN, DOWN, UP)-1:0]   m_data_o,
  output logic                                       m_last_o
);

  localparam int SW = subword_width(DWIDTH_IN, DOWN);
  localparam int OW = out_width(DWIDTH_IN, DOWN, UP);
  localparam int CW = count_width(UP);

  logic [OW-1:0] shift_q;
  logic [OW-1:0] shift_next;
  logic [OW-1:0] flush_word;
  logic [CW-1:0] fill_q;
  logic          valid_q;
  logic [OW-1:0] data_q;
  logic          last_q;
  logic          s_fire;
  logic          word_done;
  int            pad_slots;

  assign s_fire    = s_valid_i && s_ready_o;
  assign word_done = s_last_i || (fill_q == CW'(UP - 1));

  // accept while the output register is free or drains this cycle
  assign s_ready_o = !valid_q || m_ready_i;

  assign m_valid_o = valid_q;
  assign m_data_o  = data_q;
  assign m_last_o  = last_q;

  always_comb begin
    // new subword enters at the top slot, older ones move down
    shift_next = (OW'(s_data_i) << (OW - SW)) | (shift_q >> SW);
    // a short word sits in the upper slots; shift it down so slot 0 holds
    // the first subword, stale low slots drop out and zeros fill the top
    pad_slots  = (UP - 1) - int'(fill_q);
    flush_word = shift_next >> (pad_slots * SW);
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      fill_q  <= '0;
    end else begin
      // a finished word refills the output register, otherwise it empties
      // once its word is taken, even while a subword is being collected
      if (s_fire && word_done) begin
        valid_q <= 1'b1;
      end else if (valid_q && m_ready_i) begin
        valid_q <= 1'b0;
      end
      if (s_fire) begin
        if (word_done) begin
          fill_q <= '0;
        end else begin
          fill_q <= fill_q + CW'(1);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s_fire) begin
      shift_q <= shift_next;
      if (word_done) begin
        data_q <= flush_word;
        last_q <= s_last_i;
      end
    end
  end

endmodule

//--- include/axis_resize_defs.svh
// axis width converter shared definitions
// port width limit and default converter setting
`ifndef AXIS_RESIZE_DEFS_SVH
`define AXIS_RESIZE_DEFS_SVH

// widest port any stage may be built with
`define AXIS_RESIZE_MAX_WIDTH 512

// default setting: 24-bit in, 3 subwords of 8 bits, 2 subwords per output
`define AXIS_RESIZE_DEF_DWIDTH_IN 24
`define AXIS_RESIZE_DEF_DOWN 3
`define AXIS_RESIZE_DEF_UP 2

`endif

//--- run_sim.sh
#!/bin/sh
# Build and run the axis width converter testbench with Verilator.
# Exit status is non-zero when the build, the run or the log check fails.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=tb_axis_resize_top

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module "$TOP" \
  --Mdir "$BUILD_DIR" \
  -f axis_resize_top.f \
  -o "$TOP"
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG_FILE"; then
  echo "failure reported in $LOG_FILE"
  exit 1
fi

echo "no failure reported in $LOG_FILE"
exit 0

//--- sim/axis_resize_checker.sv
// axis width converter handshake checker
// bound into the converter top, watches both stream ports for protocol slips
`timescale 1ns/1ps

module axis_resize_checker #(
  parameter int OW = 16
) (
  input logic          clk,
  input logic          rst_n_i,
  input logic          s_valid_i,
  input logic          s_ready_i,
  input logic          m_valid_i,
  input logic          m_ready_i,
  input logic [OW-1:0] m_data_i,
  input logic          m_last_i
);

  // a reset edge always empties the output slice
  a_reset_clears_valid: assert property (
    @(posedge clk) !rst_n_i |=> !m_valid_i
  ) else $error("m_valid_o still high after a reset edge");

  // stalled output beat must hold until taken
  a_out_valid_held: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    m_valid_i && !m_ready_i |=> m_valid_i
  ) else $error("m_valid_o dropped before its beat was taken");

  a_out_payload_held: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    m_valid_i && !m_ready_i |=> $stable(m_data_i) && $stable(m_last_i)
  ) else $error("m_data_o or m_last_o changed while the output was stalled");

  // input ready is not withdrawn while no beat is offered
  a_in_ready_held: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    s_ready_i && !s_valid_i |=> s_ready_i
  ) else $error("s_ready_o fell while the input was idle");

endmodule

bind axis_resize_top axis_resize_checker #(
  .OW(OW)
) u_checker (
  .clk      (clk),
  .rst_n_i  (rst_n_i),
  .s_valid_i(s_valid_i),
  .s_ready_i(s_ready_o),
  .m_valid_i(m_valid_o),
  .m_ready_i(m_ready_i),
  .m_data_i (m_data_o),
  .m_last_i (m_last_o)
);

//--- sim/tb_axis_resize_top.sv
// testbench for the axis width converter
// random frames with gaps and back-pressure, reference packing model,
// output comparison and a mid-frame reset
`timescale 1ns/1ps
`include "axis_resize_defs.svh"

module tb_axis_resize_top;

  localparam int DWIDTH_IN = `AXIS_RESIZE_DEF_DWIDTH_IN;
  localparam int DOWN      = `AXIS_RESIZE_DEF_DOWN;
  localparam int UP        = `AXIS_RESIZE_DEF_UP;
  localparam int SW        = DWIDTH_IN / DOWN;
  localparam int OW        = SW * UP;
  localparam int SEND_TIMEOUT  = 500;
  localparam int DRAIN_TIMEOUT = 3000;

  logic                 clk;
  logic                 rst_n;
  logic                 s_valid;
  logic                 s_ready;
  logic [DWIDTH_IN-1:0] s_data;
  logic                 s_last;
  logic                 m_valid;
  logic                 m_ready;
  logic [OW-1:0]        m_data;
  logic                 m_last;

  // expected output words, oldest first
  logic [OW-1:0] exp_data[$];
  bit            exp_last[$];

  int mismatch_count;
  int fail_count;
  bit aborted;
  // 0 ready always, 1 random stalls, 2 ready held low
  int bp_mode;
  int stall_left;

  axis_resize_top uut (
    .clk      (clk),
    .rst_n_i  (rst_n),
    .s_valid_i(s_valid),
    .s_ready_o(s_ready),
    .s_data_i (s_data),
    .s_last_i (s_last),
    .m_valid_o(m_valid),
    .m_ready_i(m_ready),
    .m_data_o (m_data),
    .m_last_o (m_last)
  );

  always #10 clk = ~clk;

  // split each word little-endian, pack UP subwords per output word,
  // zero the unused slots of a short final word and mark it last
  function automatic void predict_frame(input logic [DWIDTH_IN-1:0] words[$]);
    logic [OW-1:0] acc;
    int            fill;
    int            seen;
    int            total;
    acc   = '0;
    fill  = 0;
    seen  = 0;
    total = words.size() * DOWN;
    foreach (words[i]) begin
      for (int k = 0; k < DOWN; k++) begin
        acc[fill*SW +: SW] = SW'(words[i] >> (k * SW));
        fill++;
        seen++;
        if (fill == UP || seen == total) begin
          exp_data.push_back(acc);
          exp_last.push_back(seen == total);
          acc  = '0;
          fill = 0;
        end
      end
    end
  endfunction

  // output monitor, compares every accepted output word
  always @(posedge clk) begin : monitor
    logic [OW-1:0] want_data;
    bit            want_last;
    if (rst_n && m_valid && m_ready) begin
      if (exp_data.size() == 0) begin
        $display("unexpected output word %h arrived with nothing pending", m_data);
        fail_count++;
      end else begin
        want_data = exp_data.pop_front();
        want_last = exp_last.pop_front();
        if (m_data !== want_data) begin
          $display("MISMATCH m_data_o: expected %h, got %h", want_data, m_data);
          mismatch_count++;
        end
        if (m_last !== want_last) begin
          $display("MISMATCH m_last_o: expected %h, got %h", want_last, m_last);
          mismatch_count++;
        end
      end
    end
  end

  // output back-pressure, long stalls now and then
  always @(negedge clk) begin
    if (bp_mode == 0) begin
      m_ready = 1'b1;
    end else if (bp_mode == 2) begin
      m_ready = 1'b0;
    end else if (stall_left > 0) begin
      m_ready = 1'b0;
      stall_left--;
    end else if ($urandom_range(99) < 6) begin
      stall_left = $urandom_range(40, 5);
      m_ready    = 1'b0;
    end else begin
      m_ready = ($urandom_range(99) < 65);
    end
  end

  // called just after a falling edge, returns just after a falling edge
  task automatic send_word(input logic [DWIDTH_IN-1:0] data, input logic last);
    int waited;
    waited = 0;
    if (!aborted) begin
      s_valid = 1'b1;
      s_data  = data;
      s_last  = last;
      // ready is registered, so its value here holds through the next rise
      while (!s_ready && waited < SEND_TIMEOUT) begin
        @(negedge clk);
        waited++;
      end
      if (!s_ready) begin
        $display("timeout: input word was never accepted");
        fail_count++;
        aborted = 1'b1;
      end else begin
        @(negedge clk);
      end
      s_valid = 1'b0;
      s_last  = 1'b0;
    end
  endtask

  task automatic send_frame(input int n_words, input int gap_pct);
    logic [DWIDTH_IN-1:0] frame_words[$];
    int                   gap;
    for (int i = 0; i < n_words; i++) begin
      frame_words.push_back(DWIDTH_IN'($urandom));
    end
    predict_frame(frame_words);
    foreach (frame_words[i]) begin
      send_word(frame_words[i], i == n_words - 1);
      if (gap_pct > 0 && $urandom_range(99) < gap_pct) begin
        gap = $urandom_range(4, 1);
        repeat (gap) @(negedge clk);
      end
    end
  endtask

  task automatic run_frames(input int count, input int gap_pct,
                            input int min_words, input int max_words);
    for (int f = 0; f < count; f++) begin
      if (!aborted) begin
        send_frame($urandom_range(max_words, min_words), gap_pct);
      end
    end
  endtask

  task automatic drain_outputs();
    int waited;
    waited = 0;
    while (exp_data.size() != 0 && waited < DRAIN_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (exp_data.size() != 0) begin
      $display("timeout: %0d expected output words never arrived", exp_data.size());
      fail_count++;
      aborted = 1'b1;
    end else begin
      // a few idle cycles so stray extra words show up
      repeat (8) @(negedge clk);
    end
  endtask

  // reset while a frame is stuck inside the pipeline
  task automatic reset_mid_frame();
    bp_mode = 2;
    send_word(DWIDTH_IN'($urandom), 1'b0);
    send_word(DWIDTH_IN'($urandom), 1'b0);
    rst_n = 1'b0;
    exp_data.delete();
    exp_last.delete();
    repeat (3) @(negedge clk);
    if (m_valid) begin
      $display("m_valid_o is high while reset is applied");
      fail_count++;
    end
    rst_n   = 1'b1;
    bp_mode = 0;
    @(negedge clk);
    if (m_valid) begin
      $display("m_valid_o went high after reset with no input sent");
      fail_count++;
    end
    send_frame(3, 0);
    drain_outputs();
  endtask

  initial begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    s_valid        = 1'b0;
    s_data         = '0;
    s_last         = 1'b0;
    m_ready        = 1'b0;
    bp_mode        = 0;
    stall_left     = 0;
    mismatch_count = 0;
    fail_count     = 0;
    aborted        = 1'b0;
    void'($urandom(70750));

    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // full rate, 4 words give a whole number of output words
    send_frame(4, 0);
    if (!aborted) drain_outputs();

    // random input gaps
    if (!aborted) run_frames(6, 40, 1, 6);
    if (!aborted) drain_outputs();

    // random back-pressure on top of the gaps
    bp_mode = 1;
    if (!aborted) run_frames(8, 30, 1, 6);
    if (!aborted) drain_outputs();
    bp_mode = 0;

    // short frames that end on a partly filled output word
    if (!aborted) send_frame(1, 0);
    if (!aborted) send_frame(3, 0);
    if (!aborted) send_frame(1, 20);
    if (!aborted) drain_outputs();

    if (!aborted) reset_mid_frame();

    $display("checks done: %0d mismatches, %0d other failures",
             mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
